//--- Makefile
TOP := tb_msx_devices

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- cpu_bus_if.sv
//////////////////////////////
// CPU I/O bus
// Carries one Z80 I/O cycle from the top
// level to every device
//////////////////////////////

`timescale 1ns/100ps

interface cpu_bus_if;

    logic [7:0] addr;
    logic [7:0] wdata;
    logic       wr;
    logic       rd;
    logic       clk;

    // Driven by the top level
    modport host_mp (
        output addr,
        output wdata,
        output wr,
        output rd,
        output clk
    );

    // Devices only listen
    modport device_mp (
        input addr,
        input wdata,
        input wr,
        input rd,
        input clk
    );

endinterface

//--- dev_ppi.sv
//////////////////////////////
// 8255 PPI device
// Slot register, keyboard row scan and
// port C with key-click
//////////////////////////////

`timescale 1ns/100ps

module dev_ppi #(
    parameter logic [7:0] BASE = 8'hA8
) (
    input  logic         clk,
    input  logic         rst_n,
    cpu_bus_if.device_mp bus,
    input  logic [63:0]  kb_matrix,
    output logic [7:0]   data,
    output logic [7:0]   slot_config,
    output logic         keybeep
);

    localparam logic [7:0] ADDR_SLOT  = BASE + msx_pkg::PPI_OFS_SLOT;
    localparam logic [7:0] ADDR_KEYS  = BASE + msx_pkg::PPI_OFS_KEYS;
    localparam logic [7:0] ADDR_PORTC = BASE + msx_pkg::PPI_OFS_PORTC;
    localparam logic [7:0] ADDR_CTRL  = BASE + msx_pkg::PPI_OFS_CTRL;

    logic [7:0] port_c;
    logic [7:0] row_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_config <= 8'h00;
            port_c      <= 8'h00;
        end else if (bus.wr) begin
            case (bus.addr)
                ADDR_SLOT:  slot_config <= bus.wdata;
                ADDR_PORTC: port_c      <= bus.wdata;
                ADDR_CTRL: begin
                    // Bit set/reset only, mode words are ignored
                    if (!bus.wdata[7]) begin
                        port_c[bus.wdata[3:1]] <= bus.wdata[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Matrix holds rows 0 to 7, higher rows read as no key pressed
    assign row_data = port_c[3] ? msx_pkg::BUS_IDLE : kb_matrix[{port_c[2:0], 3'b000} +: 8];
    assign keybeep  = port_c[7];

    always_comb begin
        data = msx_pkg::BUS_IDLE;
        if (bus.rd) begin
            case (bus.addr)
                ADDR_SLOT:  data = slot_config;
                ADDR_KEYS:  data = row_data;
                ADDR_PORTC: data = port_c;
                default:    data = msx_pkg::BUS_IDLE;
            endcase
        end
    end

    // The host never drives a read and a write in one cycle
    a_no_rd_wr: assert property (
        @(posedge bus.clk) disable iff (!rst_n)
        !(bus.wr && bus.rd)
    );

endmodule

//--- dev_psg.sv
//////////////////////////////
// PSG sound device
// Register file, tone channel A, envelope,
// mixer and joystick read-back
//////////////////////////////

`timescale 1ns/100ps

module dev_psg #(
    parameter logic [7:0] BASE     = 8'hA0,
    parameter int         PRESCALE = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    cpu_bus_if.device_mp       bus,
    input  logic [5:0]         joy,
    output logic [7:0]         data,
    output logic signed [15:0] sound
);

    localparam logic [7:0] ADDR_LATCH = BASE + msx_pkg::PSG_OFS_LATCH;
    localparam logic [7:0] ADDR_WRITE = BASE + msx_pkg::PSG_OFS_WRITE;
    localparam logic [7:0] ADDR_READ  = BASE + msx_pkg::PSG_OFS_READ;
    localparam int         PW         = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [3:0]          reg_sel;
    logic [7:0]          regs [16];
    logic [PW-1:0]       presc;
    logic                tick;
    logic                reg_wr;
    logic                tone_restart;
    logic                env_restart;
    logic                env_timer_restart;
    logic                tone_pulse;
    logic                env_pulse;
    logic                square;
    logic [3:0]          env_level;
    logic [3:0]          level;
    logic [15:0]         amp;
    msx_pkg::env_shape_t shape;

    assign reg_wr       = bus.wr && (bus.addr == ADDR_WRITE);
    assign tone_restart = reg_wr && (reg_sel == msx_pkg::REG_TONE_FINE ||
                                     reg_sel == msx_pkg::REG_TONE_COARSE);
    assign env_restart  = reg_wr && (reg_sel == msx_pkg::REG_ENV_SHAPE);
    assign env_timer_restart = env_restart || (reg_wr && (reg_sel == msx_pkg::REG_ENV_FINE ||
                                                          reg_sel == msx_pkg::REG_ENV_COARSE));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_sel <= 4'd0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (bus.wr && bus.addr == ADDR_LATCH) begin
            reg_sel <= bus.wdata[3:0];
        end else if (reg_wr) begin
            regs[reg_sel] <= bus.wdata;
        end
    end

    // Shared prescaler, realigned by any generator restart
    assign tick = (presc == PW'(PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (tone_restart || env_timer_restart || tick) begin
            presc <= '0;
        end else begin
            presc <= presc + PW'(1);
        end
    end

    psg_tone #(.WIDTH(12)) u_tone (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .restart (tone_restart),
        .period  ({regs[msx_pkg::REG_TONE_COARSE][3:0], regs[msx_pkg::REG_TONE_FINE]}),
        .pulse   (tone_pulse)
    );

    psg_tone #(.WIDTH(16)) u_env_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .restart (env_timer_restart),
        .period  ({regs[msx_pkg::REG_ENV_COARSE], regs[msx_pkg::REG_ENV_FINE]}),
        .pulse   (env_pulse)
    );

    // New shape is taken straight from the bus on the restarting write
    assign shape = env_restart ? msx_pkg::env_shape_t'(bus.wdata[3:0])
                               : msx_pkg::env_shape_t'(regs[msx_pkg::REG_ENV_SHAPE][3:0]);

    psg_envelope u_env (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (env_restart),
        .shape   (shape),
        .step    (env_pulse),
        .level   (env_level)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            square <= 1'b0;
        end else if (tone_pulse) begin
            square <= ~square;
        end
    end

    // Mixer bit 0 set means the tone is off and the level passes through
    assign level = regs[msx_pkg::REG_AMPLITUDE][4] ? env_level
                                                   : regs[msx_pkg::REG_AMPLITUDE][3:0];
    assign amp   = 16'(level) * msx_pkg::LEVEL_SCALE;
    assign sound = (regs[msx_pkg::REG_MIXER][0] || square) ? $signed(amp) : 16'sd0;

    always_comb begin
        data = msx_pkg::BUS_IDLE;
        if (bus.rd && bus.addr == ADDR_READ) begin
            if (reg_sel == msx_pkg::REG_PORT_A) begin
                data = {2'b11, joy};
            end else begin
                data = regs[reg_sel];
            end
        end
    end

endmodule

//--- files.f
msx_pkg.sv
cpu_bus_if.sv
psg_tone.sv
psg_envelope.sv
dev_psg.sv
dev_ppi.sv
msx_devices.sv
tb_msx_devices.sv

//--- msx_devices.sv
//////////////////////////////
// MSX I/O device block
// Decodes I/O cycles for the PSG and PPI
// and merges their data and sound
//////////////////////////////

`timescale 1ns/100ps

module msx_devices #(
    parameter logic [7:0] PSG_BASE = 8'hA0,
    parameter logic [7:0] PPI_BASE = 8'hA8,
    parameter int         PRESCALE = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         io_addr,
    input  logic [7:0]         io_data,
    input  logic               io_wr,
    input  logic               io_rd,
    input  logic [5:0]         joy,
    input  logic [63:0]        kb_matrix,
    output logic [7:0]         data,
    output logic signed [15:0] sound,
    output logic [7:0]         slot_config,
    output logic               keybeep
);

    cpu_bus_if bus ();

    logic [7:0]         psg_data;
    logic [7:0]         ppi_data;
    logic signed [15:0] psg_sound;
    logic [15:0]        beep_term;

    assign bus.clk   = clk;
    assign bus.addr  = io_addr;
    assign bus.wdata = io_data;
    assign bus.wr    = io_wr;
    assign bus.rd    = io_rd;

    dev_psg #(.BASE(PSG_BASE), .PRESCALE(PRESCALE)) u_psg (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.device_mp),
        .joy   (joy),
        .data  (psg_data),
        .sound (psg_sound)
    );

    dev_ppi #(.BASE(PPI_BASE)) u_ppi (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.device_mp),
        .kb_matrix   (kb_matrix),
        .data        (ppi_data),
        .slot_config (slot_config),
        .keybeep     (keybeep)
    );

    // Idle devices return FF, so AND selects the active one
    assign data = psg_data & ppi_data;

    assign beep_term = keybeep ? msx_pkg::BEEP_LEVEL : 16'd0;
    assign sound     = psg_sound + $signed(beep_term);

endmodule

//--- msx_pkg.sv
//////////////////////////////
// MSX device package
// Register numbers, port offsets, envelope types
// and bus constants shared by the devices
//////////////////////////////

package msx_pkg;

    // PSG register numbers as seen through the address latch
    typedef enum logic [3:0] {
        REG_TONE_FINE   = 4'd0,
        REG_TONE_COARSE = 4'd1,
        REG_MIXER       = 4'd7,
        REG_AMPLITUDE   = 4'd8,
        REG_ENV_FINE    = 4'd11,
        REG_ENV_COARSE  = 4'd12,
        REG_ENV_SHAPE   = 4'd13,
        REG_PORT_A      = 4'd14
    } psg_reg_e;

    // PSG port offsets from the PSG base
    localparam logic [7:0] PSG_OFS_LATCH = 8'd0;
    localparam logic [7:0] PSG_OFS_WRITE = 8'd1;
    localparam logic [7:0] PSG_OFS_READ  = 8'd2;

    // PPI port offsets from the PPI base
    localparam logic [7:0] PPI_OFS_SLOT  = 8'd0;
    localparam logic [7:0] PPI_OFS_KEYS  = 8'd1;
    localparam logic [7:0] PPI_OFS_PORTC = 8'd2;
    localparam logic [7:0] PPI_OFS_CTRL  = 8'd3;

    // Low nibble of PSG register 13
    typedef struct packed {
        logic cont;
        logic attack;
        logic alternate;
        logic hold;
    } env_shape_t;

    typedef enum logic [1:0] {
        ENV_IDLE = 2'd0,
        ENV_RUN  = 2'd1,
        ENV_HOLD = 2'd2
    } env_state_t;

    // Value an unselected device puts on the data bus
    localparam logic [7:0]  BUS_IDLE    = 8'hFF;
    localparam logic [15:0] LEVEL_SCALE = 16'd1024;
    localparam logic [15:0] BEEP_LEVEL  = 16'd4096;

endpackage

//--- psg_envelope.sv
//////////////////////////////
// PSG envelope generator
// Steps a 4-bit level up or down by the
// shape bits, then repeats or holds
//////////////////////////////

`timescale 1ns/100ps

module psg_envelope (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                restart,
    input  msx_pkg::env_shape_t shape,
    input  logic                step,
    output logic [3:0]          level
);

    msx_pkg::env_state_t state;
    logic [3:0]          cnt;
    logic                dir;        // 1 while counting up
    logic [3:0]          hold_level;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= msx_pkg::ENV_IDLE;
            cnt        <= 4'd0;
            dir        <= 1'b0;
            hold_level <= 4'd0;
        end else if (restart) begin
            state <= msx_pkg::ENV_RUN;
            cnt   <= 4'd0;
            dir   <= shape.attack;
        end else if (state == msx_pkg::ENV_RUN && step) begin
            if (cnt != 4'd15) begin
                cnt <= cnt + 4'd1;
            end else if (!shape.cont) begin
                // One-shot shapes end at zero
                state      <= msx_pkg::ENV_HOLD;
                hold_level <= 4'd0;
            end else if (shape.hold) begin
                state      <= msx_pkg::ENV_HOLD;
                hold_level <= (shape.attack ^ shape.alternate) ? 4'd15 : 4'd0;
            end else begin
                // Repeat, flipping direction for triangle shapes
                cnt <= 4'd0;
                if (shape.alternate) begin
                    dir <= ~dir;
                end
            end
        end
    end

    always_comb begin
        case (state)
            msx_pkg::ENV_RUN: begin
                level = dir ? cnt : (4'd15 - cnt);
            end
            msx_pkg::ENV_HOLD: begin
                level = hold_level;
            end
            default: begin
                level = 4'd0;
            end
        endcase
    end

    // Once held, the level is frozen until the next restart
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == msx_pkg::ENV_HOLD && !restart) |=> $stable(level)
    );

endmodule

//--- psg_tone.sv
//////////////////////////////
// PSG period counter
// One pulse per programmed number of ticks
//////////////////////////////

`timescale 1ns/100ps

module psg_tone #(
    parameter int WIDTH = 12
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic             restart,
    input  logic [WIDTH-1:0] period,
    output logic             pulse
);

    logic [WIDTH-1:0] count;
    logic [WIDTH-1:0] eff_period;

    // Period 0 behaves as period 1
    assign eff_period = (period == '0) ? WIDTH'(1) : period;

    // Last tick of the period fires the pulse in the same cycle
    assign pulse = tick && (count == eff_period - WIDTH'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;
        end else if (pulse) begin
            count <= '0;
        end else if (tick) begin
            count <= count + WIDTH'(1);
        end
    end

    // Period only changes together with a restart, so the count never overruns
    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count < eff_period
    );

endmodule

//--- tb_msx_devices.sv
//////////////////////////////
// MSX device block testbench
// Directed tests of the PPI, PSG registers,
// tone period and envelope shapes
//////////////////////////////

`timescale 1ns/100ps

module tb_msx_devices;

    localparam int         CLK_PERIOD  = 10;
    localparam int         PRESCALE    = 16;
    localparam logic [7:0] PSG_BASE    = 8'hA0;
    localparam logic [7:0] PPI_BASE    = 8'hA8;
    // Reset 20, PPI 100, PSG access 90, tone 700, envelope 1340
    localparam int         TEST_CYCLES = 20 + 100 + 90 + 700 + 1340;

    logic               clk;
    logic               rst_n;
    logic [7:0]         io_addr;
    logic [7:0]         io_data;
    logic               io_wr;
    logic               io_rd;
    logic [5:0]         joy;
    logic [63:0]        kb_matrix;
    logic [7:0]         data;
    logic signed [15:0] sound;
    logic [7:0]         slot_config;
    logic               keybeep;

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          env_levels[$];

    msx_devices u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[62:0], lfsr[0]};
        end
    endtask

    task automatic compare(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("ERR t=%0t %s got=%0d expected=%0d", $time, name, got, expected);
        end
    endtask

    task automatic io_write(input logic [7:0] addr, input logic [7:0] value);
        @(posedge clk);
        io_addr <= addr;
        io_data <= value;
        io_wr   <= 1'b1;
        @(posedge clk);
        io_wr   <= 1'b0;
    endtask

    // Read data is combinational, so it is taken mid-cycle
    task automatic io_read(input logic [7:0] addr, output logic [7:0] value);
        @(posedge clk);
        io_addr <= addr;
        io_rd   <= 1'b1;
        @(negedge clk);
        value = data;
        @(posedge clk);
        io_rd   <= 1'b0;
    endtask

    task automatic psg_write_reg(input logic [3:0] num, input logic [7:0] value);
        io_write(PSG_BASE + msx_pkg::PSG_OFS_LATCH, {4'h0, num});
        io_write(PSG_BASE + msx_pkg::PSG_OFS_WRITE, value);
    endtask

    task automatic psg_read_reg(input logic [3:0] num, output logic [7:0] value);
        io_write(PSG_BASE + msx_pkg::PSG_OFS_LATCH, {4'h0, num});
        io_read(PSG_BASE + msx_pkg::PSG_OFS_READ, value);
    endtask

    task automatic reset_and_idle();
        logic [7:0] rd;
        @(negedge clk);
        compare("sound", int'(sound), 0);
        compare("slot_config", int'(slot_config), 0);
        compare("keybeep", int'(keybeep), 0);
        compare("data idle", int'(data), 8'hFF);
        io_read(8'h10, rd);
        compare("data port 10", int'(rd), 8'hFF);
        psg_read_reg(4'd0, rd);
        compare("psg reg 0 after reset", int'(rd), 0);
    endtask

    task automatic ppi_registers();
        logic [63:0] rnd;
        logic [63:0] kb;
        logic [7:0]  rd;
        repeat (4) begin
            random_bits(8, rnd);
            io_write(PPI_BASE + msx_pkg::PPI_OFS_SLOT, rnd[7:0]);
            io_read(PPI_BASE + msx_pkg::PPI_OFS_SLOT, rd);
            compare("slot readback", int'(rd), int'(rnd[7:0]));
            compare("slot_config", int'(slot_config), int'(rnd[7:0]));
        end
        random_bits(64, kb);
        kb_matrix <= kb;
        repeat (4) begin
            random_bits(3, rnd);
            io_write(PPI_BASE + msx_pkg::PPI_OFS_PORTC, {5'b0, rnd[2:0]});
            io_read(PPI_BASE + msx_pkg::PPI_OFS_KEYS, rd);
            compare($sformatf("keyboard row %0d", rnd[2:0]), int'(rd),
                    int'(kb[8 * rnd[2:0] +: 8]));
        end
        io_write(PPI_BASE + msx_pkg::PPI_OFS_PORTC, 8'h0A);
        io_read(PPI_BASE + msx_pkg::PPI_OFS_KEYS, rd);
        compare("keyboard row 10", int'(rd), 8'hFF);
        // Bit set/reset of port C bit 7
        io_write(PPI_BASE + msx_pkg::PPI_OFS_CTRL, 8'h0F);
        @(negedge clk);
        compare("keybeep set", int'(keybeep), 1);
        compare("sound with beep", int'(sound), 4096);
        io_read(PPI_BASE + msx_pkg::PPI_OFS_PORTC, rd);
        compare("port C", int'(rd), 8'h8A);
        io_write(PPI_BASE + msx_pkg::PPI_OFS_CTRL, 8'h0E);
        @(negedge clk);
        compare("keybeep cleared", int'(keybeep), 0);
        compare("sound without beep", int'(sound), 0);
        io_write(PPI_BASE + msx_pkg::PPI_OFS_CTRL, 8'h8F);
        io_read(PPI_BASE + msx_pkg::PPI_OFS_PORTC, rd);
        compare("port C after mode word", int'(rd), 8'h0A);
    endtask

    task automatic psg_register_access();
        int          nums[8];
        logic [7:0]  values[8];
        logic [63:0] rnd;
        logic [7:0]  rd;
        nums = '{0, 1, 7, 8, 11, 12, 13, 15};
        for (int i = 0; i < 8; i++) begin
            random_bits(8, rnd);
            values[i] = rnd[7:0];
            psg_write_reg(4'(nums[i]), values[i]);
        end
        for (int i = 0; i < 8; i++) begin
            psg_read_reg(4'(nums[i]), rd);
            compare($sformatf("psg reg %0d", nums[i]), int'(rd), int'(values[i]));
        end
        random_bits(6, rnd);
        joy <= rnd[5:0];
        psg_read_reg(msx_pkg::REG_PORT_A, rd);
        compare("psg reg 14", int'(rd), int'({2'b11, rnd[5:0]}));
    endtask

    // First edge only syncs and the next six half periods are timed
    task automatic measure_half_periods(input int half);
        int prev;
        int cycles;
        int edges;
        int waited;
        edges  = 0;
        cycles = 0;
        waited = 0;
        @(negedge clk);
        prev = int'(sound);
        while (edges < 7 && waited < 16 * half) begin
            @(negedge clk);
            cycles++;
            waited++;
            if (int'(sound) != prev) begin
                compare("tone sound", int'(sound), (prev == 0) ? 15 * 1024 : 0);
                if (edges > 0) begin
                    compare("half period cycles", cycles, half);
                end
                edges++;
                cycles = 0;
                prev   = int'(sound);
            end
        end
        if (edges < 7) begin
            errors++;
            $display("Tone output stopped toggling after %0d edges", edges);
        end
    endtask

    task automatic tone_period();
        psg_write_reg(msx_pkg::REG_MIXER, 8'h00);
        psg_write_reg(msx_pkg::REG_AMPLITUDE, 8'h0F);
        psg_write_reg(msx_pkg::REG_TONE_COARSE, 8'h00);
        psg_write_reg(msx_pkg::REG_TONE_FINE, 8'h05);
        measure_half_periods(PRESCALE * 5);
        psg_write_reg(msx_pkg::REG_TONE_FINE, 8'h00);
        measure_half_periods(PRESCALE);
    endtask

    // Samples the middle of every envelope step after the shape write
    task automatic follow_envelope(input logic [3:0] shape);
        psg_write_reg(msx_pkg::REG_ENV_SHAPE, {4'h0, shape});
        repeat (PRESCALE / 2) @(posedge clk);
        for (int k = 0; k < env_levels.size(); k++) begin
            @(negedge clk);
            compare($sformatf("envelope %b step %0d", shape, k), int'(sound),
                    env_levels[k] * 1024);
            repeat (PRESCALE - 1) @(negedge clk);
        end
    endtask

    task automatic envelope_shapes();
        psg_write_reg(msx_pkg::REG_MIXER, 8'h01);
        psg_write_reg(msx_pkg::REG_AMPLITUDE, 8'h10);
        psg_write_reg(msx_pkg::REG_ENV_COARSE, 8'h00);
        psg_write_reg(msx_pkg::REG_ENV_FINE, 8'h01);
        env_levels.delete();
        for (int k = 0; k < 20; k++) begin
            env_levels.push_back((k < 16) ? k : 15);
        end
        follow_envelope(4'b1101);
        env_levels.delete();
        for (int k = 0; k < 20; k++) begin
            env_levels.push_back((k < 16) ? 15 - k : 0);
        end
        follow_envelope(4'b0000);
        // Triangle repeats the top and bottom level once when it turns
        env_levels.delete();
        for (int k = 0; k < 16; k++) begin
            env_levels.push_back(k);
        end
        for (int k = 0; k < 16; k++) begin
            env_levels.push_back(15 - k);
        end
        for (int k = 0; k < 8; k++) begin
            env_levels.push_back(k);
        end
        follow_envelope(4'b1110);
    endtask

    initial begin
        lfsr      = 16'd92;
        errors    = 0;
        checks    = 0;
        rst_n     <= 1'b0;
        io_addr   <= 8'h00;
        io_data   <= 8'h00;
        io_wr     <= 1'b0;
        io_rd     <= 1'b0;
        joy       <= 6'h00;
        kb_matrix <= '1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_idle();
        ppi_registers();
        psg_register_access();
        tone_period();
        envelope_shapes();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
